// ==== common/pat_pkg.sv ====
package pat_pkg;

	// ========================================
	// sizes
	// ========================================
	localparam int data_w = 8;
	localparam int addr_w = 8;      // program store address
	localparam int instr_w = 17;
	localparam int reg_sel_w = 3;
	localparam int num_regs = 8;

	// i8 opcodes
	localparam logic [3:0] opc_ori = 4'b0000;
	localparam logic [3:0] opc_orr = 4'b0001;
	localparam logic [3:0] opc_andi = 4'b0010;
	localparam logic [3:0] opc_andr = 4'b0011;
	localparam logic [3:0] opc_addi = 4'b0100;
	localparam logic [3:0] opc_addr = 4'b0101;
	localparam logic [3:0] opc_subi = 4'b0110;
	localparam logic [3:0] opc_subr = 4'b0111;
	localparam logic [3:0] opc_ldi = 4'b1000;
	localparam logic [3:0] opc_bf = 4'b1101;
	localparam logic [3:0] opc_prefix = 4'b1111;    // escape to i3, and from i3 to i0

	// i3 opcodes, sit in imm8[7:4]
	localparam logic [3:0] op3_shlzi = 4'b0000;
	localparam logic [3:0] op3_shlzr = 4'b0001;
	localparam logic [3:0] op3_shrzi = 4'b0100;
	localparam logic [3:0] op3_shrzr = 4'b0101;
	localparam logic [3:0] op3_out = 4'b1011;

	// i0 opcodes, sit in imm8[3:0]
	localparam logic [3:0] op0_not = 4'b0000;
	localparam logic [3:0] op0_test = 4'b0010;
	localparam logic [3:0] op0_nop = 4'b0101;

	localparam logic [1:0] cond_z = 2'd0;
	localparam logic [1:0] cond_nz = 2'd1;
	localparam logic [1:0] cond_n = 2'd2;
	localparam logic [1:0] cond_al = 2'd3;

	// alu operation codes
	localparam int alu_op_w = 3;
	localparam logic [alu_op_w-1:0] alu_or = 3'd0;
	localparam logic [alu_op_w-1:0] alu_and = 3'd1;
	localparam logic [alu_op_w-1:0] alu_add = 3'd2;
	localparam logic [alu_op_w-1:0] alu_sub = 3'd3;
	localparam logic [alu_op_w-1:0] alu_pass = 3'd4;   // y = b
	localparam logic [alu_op_w-1:0] alu_shl = 3'd5;
	localparam logic [alu_op_w-1:0] alu_shr = 3'd6;
	localparam logic [alu_op_w-1:0] alu_not = 3'd7;    // y = ~a

	// ========================================
	// pipeline
	// ========================================
	localparam int branch_shadow = 2;   // captures squashed after reset or a taken branch
	localparam int fetch_latency = 1;   // o_pc to i_instruction
	localparam int shadow_cnt_w = $clog2(branch_shadow + 1);

	localparam logic [1:0] st_fill = 2'd0;
	localparam logic [1:0] st_run = 2'd1;
	localparam logic [1:0] st_flush = 2'd2;

	// one instruction word, three ways of reading it
	typedef union packed {
		struct packed {
			logic [reg_sel_w-1:0] rn;
			logic [1:0] cond;
			logic [3:0] opcode;
			logic [7:0] imm8;
		} i8;
		struct packed {
			logic [reg_sel_w-1:0] rn;
			logic [1:0] cond;
			logic [3:0] prefix;
			logic [3:0] op3;
			logic pad;
			logic [2:0] imm3;
		} i3;
		struct packed {
			logic [reg_sel_w-1:0] rn;
			logic [1:0] cond;
			logic [3:0] prefix;
			logic [3:0] prefix2;
			logic [3:0] op0;
		} i0;
	} instr_u;

endpackage

// ==== common/stage_if.sv ====
`timescale 1ns/1ns

interface stage_if;
	import pat_pkg::*;

	logic valid;
	logic [reg_sel_w-1:0] rn;             // destination, also operand a
	logic [1:0] cond;
	logic [alu_op_w-1:0] alu_op;
	logic use_imm;
	logic [reg_sel_w-1:0] src_sel;        // operand b register for the r forms
	logic [data_w-1:0] imm;
	logic write_reg;
	logic is_test;
	logic is_out;
	logic is_branch;
	logic [addr_w-1:0] addr;              // address of this word, for BF

	modport decode (
		output valid, rn, cond, alu_op, use_imm, src_sel, imm,
		output write_reg, is_test, is_out, is_branch, addr
	);

	modport execute (
		input valid, rn, cond, alu_op, use_imm, src_sel, imm,
		input write_reg, is_test, is_out, is_branch, addr
	);

endinterface

// ==== execute/alu.sv ====
`timescale 1ns/1ns

module alu (
	input logic [pat_pkg::alu_op_w-1:0] i_op,
	input logic [pat_pkg::data_w-1:0] i_a,
	input logic [pat_pkg::data_w-1:0] i_b,
	output logic [pat_pkg::data_w-1:0] o_y
);
	import pat_pkg::*;

	logic is_sub;
	logic [data_w-1:0] b_in;
	logic [data_w-1:0] addsub;
	logic [2:0] shamt;

	// one adder for both, sub is a + ~b + 1
	assign is_sub = (i_op == alu_sub);
	assign b_in = is_sub ? ~i_b : i_b;
	assign addsub = i_a + b_in + {{(data_w-1){1'b0}}, is_sub};

	// shift by 1 to 4
	assign shamt = {1'b0, i_b[1:0]} + 3'd1;

	always_comb
	begin
		case (i_op)
			alu_or:  o_y = i_a | i_b;
			alu_and: o_y = i_a & i_b;
			alu_add,
			alu_sub: o_y = addsub;
			alu_pass: o_y = i_b;
			alu_shl: o_y = i_a << shamt;    // zero fill
			alu_shr: o_y = i_a >> shamt;
			alu_not: o_y = ~i_a;
			default: o_y = i_b;
		endcase
	end

endmodule

// ==== execute/register_file.sv ====
`timescale 1ns/1ns

module register_file (
	input logic clk,
	input logic [pat_pkg::reg_sel_w-1:0] i_rd_sel_a,
	input logic [pat_pkg::reg_sel_w-1:0] i_rd_sel_b,
	input logic i_wr_en,
	input logic [pat_pkg::reg_sel_w-1:0] i_wr_sel,
	input logic [pat_pkg::data_w-1:0] i_wr_data,
	output logic [pat_pkg::data_w-1:0] o_rd_a,
	output logic [pat_pkg::data_w-1:0] o_rd_b
);
	import pat_pkg::*;

	logic [data_w-1:0] regs [num_regs];

	assign o_rd_a = regs[i_rd_sel_a];    // async reads
	assign o_rd_b = regs[i_rd_sel_b];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			regs[i_wr_sel] <= i_wr_data;
	end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
	input logic clk,
	input logic reset,
	stage_if.execute stage,
	output logic o_branch_taken,
	output logic [pat_pkg::addr_w-1:0] o_branch_target,
	output logic o_jump,
	output logic [pat_pkg::data_w-1:0] o_out_data,
	output logic o_out_valid
);
	import pat_pkg::*;

	logic z;
	logic n;
	logic cond_ok;
	logic commit;
	logic [data_w-1:0] rd_a;    // register rn
	logic [data_w-1:0] rd_b;    // register src_sel
	logic [data_w-1:0] alu_b;
	logic [data_w-1:0] alu_y;

	// ========================================
	// condition and commit
	// ========================================
	always_comb
	begin
		case (stage.cond)
			cond_z:  cond_ok = z;
			cond_nz: cond_ok = !z;
			cond_n:  cond_ok = n;
			cond_al: cond_ok = 1'b1;
		endcase
	end

	assign commit = stage.valid && cond_ok;

	assign alu_b = stage.use_imm ? stage.imm : rd_b;

	alu u_alu (
		.i_op (stage.alu_op),
		.i_a  (rd_a),
		.i_b  (alu_b),
		.o_y  (alu_y)
	);

	register_file u_regs (
		.clk        (clk),
		.i_rd_sel_a (stage.rn),
		.i_rd_sel_b (stage.src_sel),
		.i_wr_en    (commit && stage.write_reg),
		.i_wr_sel   (stage.rn),
		.i_wr_data  (alu_y),
		.o_rd_a     (rd_a),
		.o_rd_b     (rd_b)
	);

	// relative to the branch's own address, imm8 signed
	assign o_branch_taken = commit && stage.is_branch;
	assign o_branch_target = stage.addr + addr_w'(signed'(stage.imm));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z <= 1'b0;
			n <= 1'b0;
			o_jump <= 1'b0;
			o_out_valid <= 1'b0;
			o_out_data <= '0;
		end
		else
		begin
			o_jump <= o_branch_taken;    // same edge the pc takes the target
			o_out_valid <= commit && stage.is_out;
			if (commit && stage.is_test)
			begin
				z <= (rd_a == '0);
				n <= rd_a[data_w-1];
			end
			if (commit && stage.is_out)
				o_out_data <= rd_a;
		end
	end

endmodule

// ==== source/pipeline_control.sv ====
`timescale 1ns/1ns

module pipeline_control (
	input logic clk,
	input logic reset,
	input logic i_branch_taken,
	output logic o_capture_valid
);
	import pat_pkg::*;

	logic [1:0] state;
	logic [shadow_cnt_w-1:0] shadow_cnt;    // squashes still to go

	// the capture at the branch edge is already a wrong-path word
	assign o_capture_valid = (state == st_run) && !i_branch_taken;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_fill;
			shadow_cnt <= shadow_cnt_w'(branch_shadow);
		end
		else if (i_branch_taken)
		begin
			// this edge counts as the first squash, also restarts a flush
			state <= (branch_shadow > 1) ? st_flush : st_run;
			shadow_cnt <= shadow_cnt_w'(branch_shadow - 1);
		end
		else
		begin
			case (state)
				st_fill, st_flush:
				begin
					if (shadow_cnt == shadow_cnt_w'(1))
						state <= st_run;    // last squashed capture
					shadow_cnt <= shadow_cnt - 1'b1;
				end
				st_run: ;
				default: state <= st_fill;
			endcase
		end
	end

endmodule

// ==== source/program_counter.sv ====
`timescale 1ns/1ns

module program_counter (
	input logic clk,
	input logic reset,
	input logic i_branch_taken,
	input logic [pat_pkg::addr_w-1:0] i_branch_target,
	output logic [pat_pkg::addr_w-1:0] o_pc,
	output logic [pat_pkg::addr_w-1:0] o_fetch_addr
);
	import pat_pkg::*;

	logic [addr_w-1:0] pc_next;
	logic [addr_w-1:0] addr_pipe [fetch_latency];

	assign pc_next = i_branch_taken ? i_branch_target : o_pc + 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else
			o_pc <= pc_next;
	end

	// follows the program store, so the word and its address line up
	always_ff @(posedge clk)
	begin
		addr_pipe[0] <= o_pc;
		for (int i = 1; i < fetch_latency; i++)
		begin
			addr_pipe[i] <= addr_pipe[i-1];
		end
	end

	assign o_fetch_addr = addr_pipe[fetch_latency-1];

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_u i_instruction,
	input logic [pat_pkg::addr_w-1:0] i_fetch_addr,
	input logic i_capture_valid,
	stage_if.decode stage
);
	import pat_pkg::*;

	instr_u instr_q;
	logic [addr_w-1:0] addr_q;
	logic valid_q;
	logic is_i8;
	logic is_i3;
	logic [alu_op_w-1:0] op_d;
	logic wr_d;

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= i_capture_valid;
		instr_q <= i_instruction;
		addr_q <= i_fetch_addr;
	end

	// format select
	assign is_i8 = (instr_q.i8.opcode != opc_prefix);
	assign is_i3 = !is_i8 && (instr_q.i3.op3 != opc_prefix);

	always_comb
	begin
		op_d = alu_pass;
		wr_d = 1'b1;
		if (is_i8)
			case (instr_q.i8.opcode)
				opc_ori, opc_orr:   op_d = alu_or;
				opc_andi, opc_andr: op_d = alu_and;
				opc_addi, opc_addr: op_d = alu_add;
				opc_subi, opc_subr: op_d = alu_sub;
				opc_ldi:            op_d = alu_pass;   // imm straight through
				default:            wr_d = 1'b0;       // bf and unused codes
			endcase
		else if (is_i3)
			case (instr_q.i3.op3)
				op3_shlzi, op3_shlzr: op_d = alu_shl;
				op3_shrzi, op3_shrzr: op_d = alu_shr;
				default:              wr_d = 1'b0;     // out and unused codes
			endcase
		else
			case (instr_q.i0.op0)
				op0_not: op_d = alu_not;
				default: wr_d = 1'b0;        // test, nop, and unknown acts as nop
			endcase
	end

	assign stage.valid = valid_q;
	assign stage.rn = instr_q.i8.rn;
	assign stage.cond = instr_q.i8.cond;
	assign stage.alu_op = op_d;
	assign stage.write_reg = wr_d;
	assign stage.use_imm = is_i8 ? !instr_q.i8.opcode[0] : !instr_q.i3.op3[0];  // even = imm
	assign stage.imm = is_i8 ? instr_q.i8.imm8 : data_w'(instr_q.i3.imm3);
	assign stage.src_sel = instr_q.i8.imm8[reg_sel_w-1:0];
	assign stage.is_branch = is_i8 && (instr_q.i8.opcode == opc_bf);
	assign stage.is_out = is_i3 && (instr_q.i3.op3 == op3_out);
	assign stage.is_test = !is_i8 && !is_i3 && (instr_q.i0.op0 == op0_test);
	assign stage.addr = addr_q;

endmodule

// ==== source/pat_core.sv ====
`timescale 1ns/1ns

module pat_core (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_u i_instruction,
	output logic [pat_pkg::addr_w-1:0] o_pc,
	output logic o_jump,
	output logic [pat_pkg::data_w-1:0] o_out_data,
	output logic o_out_valid
);
	import pat_pkg::*;

	logic capture_valid;
	logic branch_taken;
	logic [addr_w-1:0] branch_target;
	logic [addr_w-1:0] fetch_addr;    // address of the word on i_instruction

	stage_if stage_bus ();

	pipeline_control u_control (
		.clk             (clk),
		.reset           (reset),
		.i_branch_taken  (branch_taken),
		.o_capture_valid (capture_valid)
	);

	program_counter u_pc (
		.clk             (clk),
		.reset           (reset),
		.i_branch_taken  (branch_taken),
		.i_branch_target (branch_target),
		.o_pc            (o_pc),
		.o_fetch_addr    (fetch_addr)
	);

	// stage 1
	decode_stage u_decode (
		.clk             (clk),
		.reset           (reset),
		.i_instruction   (i_instruction),
		.i_fetch_addr    (fetch_addr),
		.i_capture_valid (capture_valid),
		.stage           (stage_bus.decode)
	);

	// stage 2
	execute_stage u_execute (
		.clk             (clk),
		.reset           (reset),
		.stage           (stage_bus.execute),
		.o_branch_taken  (branch_taken),
		.o_branch_target (branch_target),
		.o_jump          (o_jump),
		.o_out_data      (o_out_data),
		.o_out_valid     (o_out_valid)
	);

endmodule

// ==== tests/pat_core_assertions.sv ====
`timescale 1ns/1ns

module pat_core_assertions (
	input logic clk,
	input logic reset,
	input logic [pat_pkg::addr_w-1:0] i_pc,
	input logic i_jump,
	input logic i_out_valid
);

	// a taken branch is a single-cycle pulse
	jump_pulse: assert property (@(posedge clk) disable iff (reset) i_jump |=> !i_jump)
		else $error("o_jump stayed high for two cycles");

	// the pc moves by one unless it just took a branch target
	pc_step: assert property (@(posedge clk) disable iff (reset)
		(!$past(reset) && !i_jump) |-> (i_pc == $past(i_pc) + 1'b1))
		else $error("o_pc did not advance by one");

	out_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> !i_out_valid)
		else $error("o_out_valid set while in reset");

endmodule

// ==== tests/pat_core_tb.sv ====
`timescale 1ns/1ns

module pat_core_tb;
	import pat_pkg::*;

	localparam int max_rows = 32;
	localparam int out_timeout = 32;    // cycles per expected output
	localparam int prog_base = 1;       // word 0 is fetched during the reset fill and squashed

	logic clk;
	logic reset;
	instr_u instruction;
	logic [addr_w-1:0] pc;
	logic jump;
	logic [data_w-1:0] out_data;
	logic out_valid;

	instr_u prog [2**addr_w];           // program store
	string row_name [max_rows];
	instr_u row_word [max_rows][3];
	int row_len [max_rows];
	logic [data_w-1:0] row_expect [max_rows];
	int num_rows;
	int expected_jumps;
	int loop_row;                       // row holding the first word of the loop
	int loop_addr;                      // branch target of the loop
	logic [31:0] rng;
	int errors;
	int checks;
	int out_count = 0;
	int jump_count = 0;

	pat_core u_dut (
		.clk           (clk),
		.reset         (reset),
		.i_instruction (instruction),
		.o_pc          (pc),
		.o_jump        (jump),
		.o_out_data    (out_data),
		.o_out_valid   (out_valid)
	);

	bind pat_core pat_core_assertions u_assertions (
		.clk         (clk),
		.reset       (reset),
		.i_pc        (o_pc),
		.i_jump      (o_jump),
		.i_out_valid (o_out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		instruction <= prog[pc];    // word for the old pc shows up after the edge

	always @(negedge clk)
	begin
		if (!reset && out_valid)
			out_count++;
		if (!reset && jump)
		begin
			jump_count++;
			check_value("jump_target", 32'(loop_addr), 32'(pc));    // pc moves with the pulse
		end
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] rand_byte();
		rng = xorshift32(rng);
		return rng[7:0];
	endfunction

	function automatic instr_u i8_word(input logic [2:0] rn, input logic [1:0] cond,
		input logic [3:0] opcode, input logic [7:0] imm);
		instr_u w;
		w.i8.rn = rn;
		w.i8.cond = cond;
		w.i8.opcode = opcode;
		w.i8.imm8 = imm;
		return w;
	endfunction

	function automatic instr_u i3_word(input logic [2:0] rn, input logic [1:0] cond,
		input logic [3:0] op3, input logic [2:0] imm3);
		instr_u w;
		w.i3.rn = rn;
		w.i3.cond = cond;
		w.i3.prefix = opc_prefix;
		w.i3.op3 = op3;
		w.i3.pad = 1'b0;
		w.i3.imm3 = imm3;
		return w;
	endfunction

	function automatic instr_u i0_word(input logic [2:0] rn, input logic [1:0] cond,
		input logic [3:0] op0);
		instr_u w;
		w.i0.rn = rn;
		w.i0.cond = cond;
		w.i0.prefix = opc_prefix;
		w.i0.prefix2 = opc_prefix;
		w.i0.op0 = op0;
		return w;
	endfunction

	function automatic instr_u out_word(input logic [2:0] rn, input logic [1:0] cond);
		return i3_word(rn, cond, op3_out, 3'd0);
	endfunction

	function automatic instr_u nop_word();
		return i0_word(3'd0, cond_al, op0_nop);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic wait_out(input string name, output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < out_timeout)
		begin
			@(negedge clk);
			seen = out_valid;
			cycles++;
		end
		if (!seen)
		begin
			errors++;
			$display("no output from the DUT for %s within %0d cycles", name, out_timeout);
		end
	endtask

	// ========================================
	// stimulus table
	// ========================================
	task automatic add_row(input string name, input instr_u w0, input instr_u w1,
		input instr_u w2, input int len, input logic [7:0] expected);
		row_name[num_rows] = name;
		row_word[num_rows][0] = w0;
		row_word[num_rows][1] = w1;
		row_word[num_rows][2] = w2;
		row_len[num_rows] = len;
		row_expect[num_rows] = expected;
		num_rows++;
	endtask

	// op on r1, then OUT r1; r forms read r2
	task automatic r1_row(input string name, input logic [3:0] opcode, input logic [7:0] operand,
		input logic [7:0] expected);
		add_row(name, i8_word(3'd1, cond_al, opcode, operand), out_word(3'd1, cond_al),
			nop_word(), 2, expected);
	endtask

	// LDI r3, shift r3, OUT r3
	task automatic shift_row(input string name, input logic [3:0] op3, input logic [2:0] imm3,
		input logic [7:0] value, input logic [7:0] expected);
		add_row(name, i8_word(3'd3, cond_al, opc_ldi, value), i3_word(3'd3, cond_al, op3, imm3),
			out_word(3'd3, cond_al), 3, expected);
	endtask

	task automatic build_table();
		logic [7:0] b;
		logic [7:0] v;
		logic [7:0] r1;
		logic [7:0] k;
		int amt;
		int cnt;
		r1 = rand_byte();
		b = rand_byte();
		r1_row("ldi_r1", opc_ldi, r1, r1);
		add_row("ldi_r2", i8_word(3'd2, cond_al, opc_ldi, b), out_word(3'd2, cond_al),
			nop_word(), 2, b);
		v = rand_byte();
		r1 = r1 + v;
		r1_row("addi", opc_addi, v, r1);
		r1 = r1 + b;
		r1_row("addr", opc_addr, 8'd2, r1);
		v = rand_byte();
		r1 = r1 - v;
		r1_row("subi", opc_subi, v, r1);
		r1 = r1 - b;
		r1_row("subr", opc_subr, 8'd2, r1);
		v = rand_byte();
		r1 = r1 | v;
		r1_row("ori", opc_ori, v, r1);
		r1 = r1 | b;
		r1_row("orr", opc_orr, 8'd2, r1);
		v = rand_byte();
		r1 = r1 & v;
		r1_row("andi", opc_andi, v, r1);
		r1 = r1 & b;
		r1_row("andr", opc_andr, 8'd2, r1);
		// immediate shift amount is imm3 + 1
		v = rand_byte();
		shift_row("shlzi_1", op3_shlzi, 3'd0, v, v << 1);
		v = rand_byte();
		shift_row("shlzi_4", op3_shlzi, 3'd3, v, v << 4);
		v = rand_byte();
		shift_row("shrzi_2", op3_shrzi, 3'd1, v, v >> 2);
		v = rand_byte();
		shift_row("shrzi_3", op3_shrzi, 3'd2, v, v >> 3);
		k = rand_byte();
		amt = int'(k[1:0]) + 1;
		add_row("ldi_r4", i8_word(3'd4, cond_al, opc_ldi, k), out_word(3'd4, cond_al),
			nop_word(), 2, k);
		v = rand_byte();
		shift_row("shlzr", op3_shlzr, 3'd4, v, v << amt);
		v = rand_byte();
		shift_row("shrzr", op3_shrzr, 3'd4, v, v >> amt);
		v = rand_byte();
		add_row("not", i8_word(3'd5, cond_al, opc_ldi, v), i0_word(3'd5, cond_al, op0_not),
			out_word(3'd5, cond_al), 3, ~v);
		// flags and conditions
		add_row("test_zero", i8_word(3'd6, cond_al, opc_ldi, 8'd0),
			i0_word(3'd6, cond_al, op0_test), out_word(3'd6, cond_z), 3, 8'd0);
		add_row("nz_skip", out_word(3'd1, cond_nz), out_word(3'd2, cond_al), nop_word(), 2, b);
		v = rand_byte() | 8'h80;
		add_row("test_neg", i8_word(3'd7, cond_al, opc_ldi, v),
			i0_word(3'd7, cond_al, op0_test), out_word(3'd7, cond_n), 3, v);
		// nop aimed at r2 leaves it untouched
		add_row("nop", i0_word(3'd2, cond_al, op0_nop), out_word(3'd2, cond_al), nop_word(), 2, b);
		// countdown loop, BF jumps back 3 words while r0 is not zero
		cnt = 2 + int'(rand_byte() % 8'd3);
		add_row("ldi_cnt", i8_word(3'd0, cond_al, opc_ldi, 8'(cnt)), out_word(3'd0, cond_al),
			nop_word(), 2, 8'(cnt));
		loop_row = num_rows;
		add_row("loop_top", i8_word(3'd0, cond_al, opc_subi, 8'd1), out_word(3'd0, cond_al),
			i0_word(3'd0, cond_al, op0_test), 3, 8'(cnt - 1));
		add_row("loop_branch", i8_word(3'd0, cond_nz, opc_bf, 8'hfd), out_word(3'd2, cond_nz),
			out_word(3'd1, cond_al), 3, 8'(cnt - 2));
		for (int i = cnt - 3; i >= 0; i--)
			add_row("loop_pass", nop_word(), nop_word(), nop_word(), 0, 8'(i));
		add_row("fall_through", nop_word(), nop_word(), nop_word(), 0, r1);
		expected_jumps = cnt - 1;
	endtask

	task automatic load_program();
		int addr;
		for (int i = 0; i < 2**addr_w; i++)
			prog[i] = nop_word();
		addr = prog_base;
		for (int r = 0; r < num_rows; r++)
		begin
			if (r == loop_row)
				loop_addr = addr;
			for (int w = 0; w < row_len[r]; w++)
			begin
				prog[addr] = row_word[r][w];
				addr++;
			end
		end
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial
	begin
		logic seen;
		logic timed_out;
		reset = 1'b1;
		instruction = nop_word();
		errors = 0;
		checks = 0;
		num_rows = 0;
		loop_row = 0;
		loop_addr = 0;
		timed_out = 1'b0;
		rng = 32'd58;
		build_table();
		load_program();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset_out_valid", 32'd0, {31'd0, out_valid});
		check_value("reset_jump", 32'd0, {31'd0, jump});
		for (int r = 0; r < num_rows && !timed_out; r++)
		begin
			wait_out(row_name[r], seen);
			if (!seen)
				timed_out = 1'b1;
			else
				check_value(row_name[r], 32'(row_expect[r]), 32'(out_data));
		end
		if (!timed_out)
		begin
			repeat (20) @(negedge clk);    // nothing may follow the fall-through output
			check_value("out_count", num_rows, out_count);
			check_value("jump_count", expected_jumps, jump_count);
		end
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== files.f ====
common/pat_pkg.sv
common/stage_if.sv
execute/alu.sv
execute/register_file.sv
execute/execute_stage.sv
source/pipeline_control.sv
source/program_counter.sv
source/decode_stage.sv
source/pat_core.sv
tests/pat_core_assertions.sv
tests/pat_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pat_core_tb -f files.f \
	-o pat_core_sim || exit 1
./obj_dir/pat_core_sim > sim.log 2>&1 || echo "simulation stopped with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log && exit 0 || exit 1
